// File: logic/dino_params.svh
// game sizing and timing constants for the dinosaur obstacle core
// included by the packages and by every module that needs a size or a count
`ifndef DINO_PARAMS_SVH
`define DINO_PARAMS_SVH

`define DINO_LANES      8            // lanes, also matrix rows
`define DINO_LANE_LEN   16           // columns per lane

`define DINO_COL        14           // dinosaur column

`define DINO_SPAWN_GAP  4            // steps between accepted patterns

`define DINO_SCORE_DIV  16           // steps per score tick

`define DINO_LIVES      3

`define DINO_SEED       32'h1D2C_3B4A

`endif

// File: logic/dino_game_pkg.sv
// obstacle and lane types shared by the spawner, the lanes, the pacer and the top level
`include "dino_params.svh"

package dino_game_pkg;

    // 00 empty, 01 one column, 11 two columns
    typedef logic [1:0] cell_t;

    // one cell per lane, lane 0 in the low bits
    typedef struct packed
    {
        cell_t [`DINO_LANES-1:0] cells;
    } pattern_t;

    typedef struct packed
    {
        logic [`DINO_LANE_LEN-1:0] cells;   // column 0 is the entry side
        logic                      hit;
    } lane_t;

    typedef logic [1:0] lives_t;

endpackage

// File: logic/dino_display_pkg.sv
// score and display types used by the score counter, the matrix scanner and the top level
`include "dino_params.svh"

package dino_display_pkg;

    typedef logic [3:0] digit_t;

    typedef struct packed
    {
        digit_t dig0;       // lowest digit
        digit_t dig1;
        digit_t dig2;
        digit_t dig3;
    } score_t;

    typedef logic [6:0] seg_t;   // active low

    typedef struct packed
    {
        logic [`DINO_LANES-1:0]    row_n;   // active low select
        logic [`DINO_LANE_LEN-1:0] cols;
    } scan_t;

endpackage

// File: logic/obstacle_spawner.sv
// picks the next obstacle pattern from a 32-bit XNOR LFSR
// offers it with valid/ready and holds it until the pacer takes it
`timescale 1ns/1ps
`include "dino_params.svh"

module obstacle_spawner
(
    input  logic                    i_unit_clk,
    input  logic                    i_restart,
    input  logic                    i_pat_ready,
    output dino_game_pkg::pattern_t o_pat,
    output logic                    o_pat_valid
);
    import dino_game_pkg::*;

    logic [31:0] lfsr_q;
    logic        feedback;
    logic        xfer;
    logic        taken_q;           // pattern went out last edge

    function automatic pattern_t pick_pattern(input logic [2:0] sel);
        case (sel)
            3'd0: pick_pattern = pattern_t'(16'hFC00);
            3'd1: pick_pattern = pattern_t'(16'h00FF);
            3'd2: pick_pattern = pattern_t'(16'hF00F);
            3'd3: pick_pattern = pattern_t'(16'hFC00);
            3'd4: pick_pattern = pattern_t'(16'hC0C3);
            3'd5: pick_pattern = pattern_t'(16'hC03F);
            3'd6: pick_pattern = pattern_t'(16'hCC0F);
            3'd7: pick_pattern = pattern_t'(16'h5C35);   // mixes short and long cells
        endcase
    endfunction

    assign feedback = lfsr_q[31] ~^ lfsr_q[21] ~^ lfsr_q[1] ~^ lfsr_q[0];   // taps 32 22 2 1
    assign xfer     = o_pat_valid & i_pat_ready;

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            lfsr_q      <= `DINO_SEED;
            o_pat_valid <= 1'b0;
            taken_q     <= 1'b0;
        end
        else
        begin
            o_pat_valid <= 1'b1;
            taken_q     <= xfer;
            if (xfer)
                lfsr_q <= {lfsr_q[30:0], feedback};
        end
    end

    // reload before the first offer and one cycle after each transfer
    always_ff @(posedge i_unit_clk)
    begin
        if (!o_pat_valid || taken_q)
            o_pat <= pick_pattern(lfsr_q[2:0]);
    end

    a_pat_held: assert property (@(posedge i_unit_clk) disable iff (!i_restart)
        o_pat_valid && !i_pat_ready && !taken_q |=> $stable(o_pat));

endmodule

// File: logic/lane_scroller.sv
// one obstacle lane, shifted toward the dinosaur on every game step
// flags a hit when an obstacle sits in the dinosaur column of a lane the dinosaur fills
`timescale 1ns/1ps
`include "dino_params.svh"

module lane_scroller
(
    input  logic                 i_unit_clk,
    input  logic                 i_restart,
    input  logic                 i_step,
    input  logic                 i_accept,
    input  dino_game_pkg::cell_t i_cell,
    input  logic                 i_dino,
    output dino_game_pkg::lane_t o_lane
);

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_lane.cells <= '0;
            o_lane.hit   <= 1'b0;
        end
        else
        begin
            if (i_accept)
                o_lane.cells <= {o_lane.cells[`DINO_LANE_LEN-2:1], i_cell};   // shift and insert
            else if (i_step)
                o_lane.cells <= {o_lane.cells[`DINO_LANE_LEN-2:0], 1'b0};
            o_lane.hit <= o_lane.cells[`DINO_COL] & i_dino;
        end
    end

endmodule

// File: logic/game_pacer.sv
// game step gating, spawn spacing and life keeping
// the step stops for good once the last life is lost, until the next reset
`timescale 1ns/1ps
`include "dino_params.svh"

module game_pacer
(
    input  logic                   i_unit_clk,
    input  logic                   i_restart,
    input  logic                   i_run,
    input  logic [`DINO_LANES-1:0] i_lane_hits,
    input  logic                   i_pat_valid,
    output logic                   o_pat_ready,
    output logic                   o_step,
    output logic                   o_accept,
    output logic                   o_hit,
    output logic                   o_game_over,
    output dino_game_pkg::lives_t  o_lives
);
    localparam int GAP_W = $clog2(`DINO_SPAWN_GAP);

    logic [GAP_W-1:0] gap_q;
    logic             gap_end;

    assign o_step      = i_run & ~o_game_over;
    assign gap_end     = (gap_q == GAP_W'(`DINO_SPAWN_GAP - 1));
    assign o_pat_ready = o_step & gap_end;
    assign o_accept    = o_pat_ready & i_pat_valid;

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            gap_q       <= '0;
            o_hit       <= 1'b0;
            o_lives     <= 2'(`DINO_LIVES);
            o_game_over <= 1'b0;
        end
        else
        begin
            if (o_step)
                gap_q <= gap_end ? '0 : gap_q + 1'b1;
            o_hit <= |i_lane_hits;
            if (o_hit && o_lives != '0)
            begin
                o_lives <= o_lives - 1'b1;
                if (o_lives == 2'd1)
                    o_game_over <= 1'b1;    // last life gone
            end
        end
    end

    a_lives_fall: assert property (@(posedge i_unit_clk) disable iff (!i_restart)
        1'b1 |=> o_lives <= $past(o_lives));

endmodule

// File: logic/score_counter.sv
// four-digit hex score that ticks once per prescale period of game steps
// also decodes each digit for an active-low seven-segment display
`timescale 1ns/1ps
`include "dino_params.svh"

module score_counter
(
    input  logic                          i_unit_clk,
    input  logic                          i_restart,
    input  logic                          i_step,
    output dino_display_pkg::score_t      o_score,
    output dino_display_pkg::seg_t  [3:0] o_segs
);
    import dino_display_pkg::*;

    localparam int PRE_W = $clog2(`DINO_SCORE_DIV);

    logic [PRE_W-1:0] pre_q;
    logic [15:0]      count_n;

    function automatic seg_t seg_decode(input digit_t d);
        case (d)
            4'h0: seg_decode = 7'b1000000;
            4'h1: seg_decode = 7'b1111001;
            4'h2: seg_decode = 7'b0100100;
            4'h3: seg_decode = 7'b0110000;
            4'h4: seg_decode = 7'b0011001;
            4'h5: seg_decode = 7'b0010010;
            4'h6: seg_decode = 7'b0000010;
            4'h7: seg_decode = 7'b1111000;
            4'h8: seg_decode = 7'b0000000;
            4'h9: seg_decode = 7'b0010000;
            4'ha: seg_decode = 7'b0001000;
            4'hb: seg_decode = 7'b0000011;
            4'hc: seg_decode = 7'b1000110;
            4'hd: seg_decode = 7'b0100001;
            4'he: seg_decode = 7'b0000110;
            4'hf: seg_decode = 7'b0001110;
        endcase
    endfunction

    // carry ripples through the digits, wraps after ffff
    assign count_n = {o_score.dig3, o_score.dig2, o_score.dig1, o_score.dig0} + 16'd1;

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            pre_q   <= '0;
            o_score <= '0;
        end
        else if (i_step)
        begin
            pre_q <= pre_q + 1'b1;                  // wraps at the prescale period
            if (pre_q == PRE_W'(`DINO_SCORE_DIV - 1))
                {o_score.dig3, o_score.dig2, o_score.dig1, o_score.dig0} <= count_n;
        end
    end

    assign o_segs[0] = seg_decode(o_score.dig0);
    assign o_segs[1] = seg_decode(o_score.dig1);
    assign o_segs[2] = seg_decode(o_score.dig2);
    assign o_segs[3] = seg_decode(o_score.dig3);

endmodule

// File: logic/matrix_scanner.sv
// dot-matrix row scan, one row per game step starting at row 0
`timescale 1ns/1ps
`include "dino_params.svh"

module matrix_scanner
(
    input  logic                                     i_unit_clk,
    input  logic                                     i_restart,
    input  logic                                     i_step,
    input  dino_game_pkg::lane_t [`DINO_LANES-1:0]   i_lanes,
    output dino_display_pkg::scan_t                  o_scan
);
    localparam int ROW_W = $clog2(`DINO_LANES);

    logic [ROW_W-1:0] row_q;

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            row_q        <= '0;
            o_scan.row_n <= '1;     // no row lit
            o_scan.cols  <= '0;
        end
        else if (i_step)
        begin
            row_q        <= row_q + 1'b1;
            o_scan.row_n <= ~(`DINO_LANES'(1) << row_q);
            o_scan.cols  <= i_lanes[row_q].cells;
        end
    end

    a_one_row: assert property (@(posedge i_unit_clk) disable iff (!i_restart)
        (&o_scan.row_n) || $onehot(~o_scan.row_n));

endmodule

// File: logic/dino_game_top.sv
// dinosaur obstacle game core: spawner, lanes, pacer, score and matrix scan
// the dinosaur's rows come in as a mask and the step runs on unit_clk
`timescale 1ns/1ps
`include "dino_params.svh"

module dino_game_top
(
    input  logic                          i_unit_clk,
    input  logic                          i_restart,
    input  logic                          i_run,
    input  logic [`DINO_LANES-1:0]        i_dino,
    output dino_display_pkg::score_t      o_score,
    output dino_display_pkg::seg_t  [3:0] o_segs,
    output dino_display_pkg::scan_t       o_scan,
    output logic                          o_hit,
    output dino_game_pkg::lives_t         o_lives,
    output logic                          o_game_over
);
    import dino_game_pkg::*;

    pattern_t                 pat;
    logic                     pat_valid;
    logic                     pat_ready;
    logic                     step;
    logic                     accept;
    lane_t [`DINO_LANES-1:0]  lanes;
    logic  [`DINO_LANES-1:0]  lane_hits;

    obstacle_spawner u_spawner
    (
        .i_unit_clk  (i_unit_clk),
        .i_restart   (i_restart),
        .i_pat_ready (pat_ready),
        .o_pat       (pat),
        .o_pat_valid (pat_valid)
    );

    for (genvar g = 0; g < `DINO_LANES; g++)
    begin : g_lane
        lane_scroller u_lane
        (
            .i_unit_clk (i_unit_clk),
            .i_restart  (i_restart),
            .i_step     (step),
            .i_accept   (accept),
            .i_cell     (pat.cells[g]),
            .i_dino     (i_dino[g]),
            .o_lane     (lanes[g])
        );
        assign lane_hits[g] = lanes[g].hit;
    end

    game_pacer u_pacer
    (
        .i_unit_clk  (i_unit_clk),
        .i_restart   (i_restart),
        .i_run       (i_run),
        .i_lane_hits (lane_hits),
        .i_pat_valid (pat_valid),
        .o_pat_ready (pat_ready),
        .o_step      (step),
        .o_accept    (accept),
        .o_hit       (o_hit),
        .o_game_over (o_game_over),
        .o_lives     (o_lives)
    );

    score_counter u_score
    (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_step     (step),
        .o_score    (o_score),
        .o_segs     (o_segs)
    );

    matrix_scanner u_scanner
    (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_step     (step),
        .i_lanes    (lanes),
        .o_scan     (o_scan)
    );

endmodule

// File: bench/dino_tb_tasks.svh
// drive, compare and directed test tasks for the dinosaur game bench
// included inside the bench module, which declares the signals and counters used here

function automatic score_t expected_score(input int steps);
    logic [15:0] v;
    score_t      s;
    begin
        v      = 16'(steps / `DINO_SCORE_DIV);     // wraps after ffff
        s.dig0 = v[3:0];
        s.dig1 = v[7:4];
        s.dig2 = v[11:8];
        s.dig3 = v[15:12];
        return s;
    end
endfunction

function automatic logic [`DINO_LANES-1:0] expected_rows(input int steps);
    if (steps == 0)
        return '1;
    return ~(`DINO_LANES'(1) << ((steps - 1) % `DINO_LANES));   // first step shows row 0
endfunction

task automatic check_score(input score_t got, input score_t exp);
    if (got !== exp)
    begin
        value_errs++;
        $display("error o_score: got %h, expected %h",
                 {got.dig3, got.dig2, got.dig1, got.dig0}, {exp.dig3, exp.dig2, exp.dig1, exp.dig0});
    end
endtask

task automatic check_segs(input string name, input seg_t got, input seg_t exp);
    if (got !== exp)
    begin
        value_errs++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_scan(input scan_t got, input scan_t exp, input bit rows_only);
    if (got.row_n !== exp.row_n || (!rows_only && got.cols !== exp.cols))
    begin
        value_errs++;
        $display("error o_scan: got %h, expected %h", got, exp);
    end
endtask

task automatic check_lives(input string name, input lives_t got, input lives_t exp);
    if (got !== exp)
    begin
        value_errs++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        value_errs++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_display;
    score_t exp;
    begin
        exp = expected_score(steps_total);
        check_score(o_score, exp);
        check_segs("o_segs[0]", o_segs[0], SEG_TABLE[exp.dig0]);
        check_segs("o_segs[1]", o_segs[1], SEG_TABLE[exp.dig1]);
        check_segs("o_segs[2]", o_segs[2], SEG_TABLE[exp.dig2]);
        check_segs("o_segs[3]", o_segs[3], SEG_TABLE[exp.dig3]);
    end
endtask

task automatic check_rows;
    scan_t exp;
    begin
        exp.row_n = expected_rows(steps_total);
        exp.cols  = '0;
        check_scan(o_scan, exp, 1'b1);
    end
endtask

task automatic check_reset_state;
    scan_t exp;
    begin
        exp.row_n = '1;
        exp.cols  = '0;
        check_display;
        check_scan(o_scan, exp, 1'b0);
        check_lives("o_lives", o_lives, 2'(`DINO_LIVES));
        check_bit("o_game_over", o_game_over, 1'b0);
        check_bit("o_hit", o_hit, 1'b0);
    end
endtask

task automatic apply_reset;
    begin
        @(posedge unit_clk);
        i_restart <= 1'b0;
        i_run     <= 1'b0;
        i_dino    <= '0;
        repeat (3) @(posedge unit_clk);
        i_restart <= 1'b1;
        steps_total = 0;
        @(negedge unit_clk);
    end
endtask

// n steps with run high, counting hits on the way
task automatic run_steps(input int n);
    int k;
    begin
        @(posedge unit_clk);
        i_run <= 1'b1;
        for (k = 0; k < n; k++)
        begin
            @(posedge unit_clk);
            steps_total++;
            if (k == n - 1)
                i_run <= 1'b0;
            @(negedge unit_clk);
            if (o_hit)
                hits_seen++;
        end
    end
endtask

task automatic test_after_reset;
    begin
        apply_reset;
        check_reset_state;
    end
endtask

task automatic test_score;
    begin
        hits_seen = 0;
        run_steps(37);
        check_display;
        run_steps(27);
        check_display;
        if (hits_seen != 0)
        begin
            other_errs++;
            $display("hit reported %0d times with an empty dinosaur mask", hits_seen);
        end
    end
endtask

task automatic test_scan;
    int k;
    begin
        for (k = 0; k < `DINO_LANES; k++)
        begin
            run_steps(1);
            check_rows;
            if ($countones(~o_scan.row_n) != 1)
            begin
                other_errs++;
                $display("row select %h does not have exactly one active row", o_scan.row_n);
            end
        end
    end
endtask

task automatic test_pause;
    scan_t scan_hold;
    begin
        @(posedge unit_clk);
        i_run <= 1'b0;
        @(negedge unit_clk);
        scan_hold = o_scan;
        repeat (25)
        begin
            @(negedge unit_clk);
            check_display;
            check_scan(o_scan, scan_hold, 1'b0);
        end
    end
endtask

// run with a dinosaur mask until the lives run out, then check the freeze
task automatic hit_run(input logic [`DINO_LANES-1:0] mask, input bit must_end);
    int     n;
    lives_t lives_exp;
    logic   hit_prev;
    scan_t  scan_hold;
    begin
        @(posedge unit_clk);
        i_dino <= mask;
        i_run  <= 1'b1;
        @(negedge unit_clk);
        lives_exp = 2'(`DINO_LIVES);
        check_lives("o_lives", o_lives, lives_exp);
        hit_prev = o_hit;
        n = 0;
        while (lives_exp != 0 && n < 40)
        begin
            @(negedge unit_clk);
            n++;
            steps_total++;
            if (hit_prev)
                lives_exp--;        // one life per hit cycle
            check_lives("o_lives", o_lives, lives_exp);
            check_bit("o_game_over", o_game_over, lives_exp == 0);
            check_display;
            check_rows;
            hit_prev = o_hit;
        end
        if (lives_exp != 0)
        begin
            if (must_end)
            begin
                other_errs++;
                $display("game over was not reached within 40 steps");
            end
        end
        else
        begin
            scan_hold = o_scan;
            repeat (10)
            begin
                @(negedge unit_clk);
                check_display;
                check_scan(o_scan, scan_hold, 1'b0);
                check_bit("o_game_over", o_game_over, 1'b1);
                check_lives("o_lives", o_lives, '0);
            end
        end
        @(posedge unit_clk);
        if (lives_exp != 0)
            steps_total++;          // run was still high on this edge
        i_run  <= 1'b0;
        i_dino <= '0;
        @(negedge unit_clk);
    end
endtask

task automatic test_hits;
    logic [`DINO_LANES-1:0] mask;
    int                     r;
    begin
        hit_run('1, 1'b1);
        for (r = 0; r < 3; r++)
        begin
            apply_reset;
            mask = `DINO_LANES'($random(seed));
            if (mask == '0)
                mask = `DINO_LANES'(1);
            hit_run(mask, 1'b0);
        end
    end
endtask

task automatic test_reset_mid;
    begin
        @(posedge unit_clk);
        i_dino <= '1;
        i_run  <= 1'b1;
        repeat (12) @(posedge unit_clk);
        apply_reset;
        check_reset_state;
    end
endtask

// File: bench/dino_game_tb.sv
// testbench for the dinosaur obstacle game core
// runs the directed tests in order, then prints the error counts and the result
`timescale 1ns/1ps
`include "dino_params.svh"

module dino_game_tb;
    import dino_game_pkg::*;
    import dino_display_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RUN_CYCLES    = 5 + 66 + 16 + 26 + 52 + 3 * 57 + 18;
    localparam int MARGIN_CYCLES = 100;

    // active-low glyphs for 0..f
    localparam seg_t SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

    logic                   unit_clk;
    logic                   i_restart;
    logic                   i_run;
    logic [`DINO_LANES-1:0] i_dino;
    score_t                 o_score;
    seg_t [3:0]             o_segs;
    scan_t                  o_scan;
    logic                   o_hit;
    lives_t                 o_lives;
    logic                   o_game_over;

    int seed = 72;
    int steps_total;    // steps since last reset
    int hits_seen;
    int value_errs;
    int other_errs;

    dino_game_top dut_i
    (
        .i_unit_clk  (unit_clk),
        .i_restart   (i_restart),
        .i_run       (i_run),
        .i_dino      (i_dino),
        .o_score     (o_score),
        .o_segs      (o_segs),
        .o_scan      (o_scan),
        .o_hit       (o_hit),
        .o_lives     (o_lives),
        .o_game_over (o_game_over)
    );

    `include "dino_tb_tasks.svh"

    initial
    begin
        unit_clk = 1'b0;
        forever #(CLK_PERIOD / 2) unit_clk = ~unit_clk;
    end

    initial
    begin
        repeat (RUN_CYCLES + MARGIN_CYCLES) @(posedge unit_clk);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        i_restart   = 1'b0;
        i_run       = 1'b0;
        i_dino      = '0;
        steps_total = 0;
        hits_seen   = 0;
        value_errs  = 0;
        other_errs  = 0;
        test_after_reset;
        test_score;
        test_scan;
        test_pause;
        test_hits;
        test_reset_mid;
        $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
+incdir+bench
logic/dino_game_pkg.sv
logic/dino_display_pkg.sv
logic/obstacle_spawner.sv
logic/lane_scroller.sv
logic/game_pacer.sv
logic/score_counter.sv
logic/matrix_scanner.sv
logic/dino_game_top.sv
bench/dino_game_tb.sv

// File: run.sh
#!/bin/sh
# build the dinosaur game bench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module dino_game_tb -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdino_game_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
